// ==== include/drac_mem_defines.svh ====
/*
 * Width, depth and command constants of the data-memory port.
 * Included by the package and by any module that sizes its own state.
 */

`ifndef DRAC_MEM_DEFINES_SVH
`define DRAC_MEM_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define DMEM_ADDR_WIDTH 40          // Physical address
`define DMEM_DATA_WIDTH 64          // Load/store data
`define DMEM_BE_WIDTH 8             // One enable per data byte
`define DMEM_SIZE_WIDTH 3           // log2 of access bytes
`define DMEM_CMD_WIDTH 5            // Walker command field

// ----------------------------------------
// Flow control
// ----------------------------------------
`define DMEM_FIFO_DEPTH 4           // Entries per requester, also its credits after reset
`define DMEM_MEM_CREDITS 3          // Memory request credits after reset

// Performance counters
`define DMEM_HPM_WIDTH 32

// Walker command for an atomic OR on a PTE
`define DMEM_WALK_CMD_AMO_OR 5'b01010

`endif

// ==== rtl/drac_mem_pkg.sv ====
/*
 * Request, response and counter types shared by the data-memory port.
 * Modules take these by a wildcard import in their header.
 */

`include "drac_mem_defines.svh"

package drac_mem_pkg;

    // ----------------------------------------
    // Scalar fields
    // ----------------------------------------
    typedef logic [`DMEM_CMD_WIDTH-1:0]  walk_cmd_t;    // Walker command code
    typedef logic [`DMEM_SIZE_WIDTH-1:0] mem_size_t;    // log2 of access bytes

    typedef enum logic [1:0] {
        LOAD   = 2'd0,
        STORE  = 2'd1,
        AMO_OR = 2'd2
    } mem_op_e;

    // Requester tag carried through memory and back
    typedef enum logic {
        SID_WALKER = 1'b0,
        SID_CORE   = 1'b1
    } sid_e;

    // ----------------------------------------
    // Requests and responses
    // ----------------------------------------
    typedef struct packed {
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        walk_cmd_t                   cmd;
        logic [`DMEM_DATA_WIDTH-1:0] wdata;
        mem_size_t                   size;
    } walk_req_t;                                       // 112 bits

    typedef struct packed {
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        logic [`DMEM_DATA_WIDTH-1:0] wdata;
        mem_op_e                     op;
        logic [`DMEM_BE_WIDTH-1:0]   be;
        mem_size_t                   size;
    } core_req_t;                                       // 117 bits

    typedef struct packed {
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        logic [`DMEM_DATA_WIDTH-1:0] wdata;
        mem_op_e                     op;
        logic [`DMEM_BE_WIDTH-1:0]   be;
        mem_size_t                   size;
        sid_e                        sid;
    } mem_req_t;                                        // 118 bits

    // Memory answer, no ready on this path
    typedef struct packed {
        sid_e                        sid;
        logic [`DMEM_DATA_WIDTH-1:0] rdata;
    } mem_rsp_t;                                        // 65 bits

    // ----------------------------------------
    // Performance counters
    // ----------------------------------------
    typedef enum logic [1:0] {
        HPM_WALK_GRANTS = 2'd0,
        HPM_CORE_GRANTS = 2'd1,
        HPM_RESPONSES   = 2'd2
    } hpm_sel_e;

    typedef logic [`DMEM_HPM_WIDTH-1:0] hpm_cnt_t;

endpackage

// ==== rtl/credit_fifo.sv ====
/*
 * Per-requester request buffer under credit flow control.
 * Sender owns DMEM_FIFO_DEPTH credits after reset; one comes back per pop.
 */

`include "drac_mem_defines.svh"

module credit_fifo #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     CLK,
    input  logic     RST,

    input  logic     push_i,        // Sender spent a credit
    input  T_PAYLOAD push_data_i,
    input  logic     pop_i,         // Head consumed this cycle
    output T_PAYLOAD head_o,
    output logic     not_empty_o,
    output logic     credit_o       // One credit back to the sender
);

    localparam int DEPTH = `DMEM_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, payload only
    T_PAYLOAD mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // ----------------------------------------
    // Pointer and occupancy update
    // ----------------------------------------
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;    // Both or neither
            endcase
        end
    end

    // Entry write, credits guarantee room
    always_ff @(posedge CLK) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);

    // Credit leaves in the same cycle the entry is released
    assign credit_o = pop_i;

endmodule

// ==== rtl/dmem_mux.sv ====
/*
 * Shares one memory request channel between page-table walker and core.
 * Translates walker commands, arbitrates round-robin under memory credits,
 * and routes responses back by source id one cycle after they arrive.
 */

`include "drac_mem_defines.svh"

module dmem_mux
    import drac_mem_pkg::*;
(
    input  logic                        CLK,
    input  logic                        RST,

    // Buffer heads
    input  walk_req_t                   walk_head_i,
    input  logic                        walk_ready_i,   // Walker buffer not empty
    input  core_req_t                   core_head_i,
    input  logic                        core_ready_i,   // Core buffer not empty
    output logic                        walk_pop_o,
    output logic                        core_pop_o,

    // Memory request channel
    input  logic                        mem_credit_i,   // One credit back from memory
    output logic                        mem_req_valid_o,
    output mem_req_t                    mem_req_o,

    // Memory response channel, no back-pressure
    input  logic                        mem_rsp_valid_i,
    input  mem_rsp_t                    mem_rsp_i,

    // Requester responses
    output logic                        walk_rsp_valid_o,
    output logic [`DMEM_DATA_WIDTH-1:0] walk_rsp_data_o,
    output logic                        core_rsp_valid_o,
    output logic [`DMEM_DATA_WIDTH-1:0] core_rsp_data_o
);

    localparam int CRD_W = $clog2(`DMEM_MEM_CREDITS + 1);

    mem_req_t walk_mem_req;
    mem_req_t core_mem_req;
    logic     is_amo_or;

    logic [CRD_W-1:0] mem_crd_q;
    logic             has_credit;
    logic             prio_core_q;      // Core wins a tie when set
    logic             walk_grant;
    logic             core_grant;
    logic             issue;

    logic                        walk_rsp_valid_q;
    logic                        core_rsp_valid_q;
    logic [`DMEM_DATA_WIDTH-1:0] rsp_data_q;

    // ----------------------------------------
    // Walker command translation
    // ----------------------------------------
    assign is_amo_or = (walk_head_i.cmd == `DMEM_WALK_CMD_AMO_OR);

    always_comb begin
        walk_mem_req.addr  = walk_head_i.addr;
        walk_mem_req.wdata = walk_head_i.wdata;
        walk_mem_req.size  = walk_head_i.size;
        walk_mem_req.op    = is_amo_or ? AMO_OR : LOAD;   // Anything else reads a PTE
        walk_mem_req.be    = is_amo_or ? '1 : '0;
        walk_mem_req.sid   = SID_WALKER;
    end

    // Core fields pass unchanged, only the tag is added
    always_comb begin
        core_mem_req.addr  = core_head_i.addr;
        core_mem_req.wdata = core_head_i.wdata;
        core_mem_req.op    = core_head_i.op;
        core_mem_req.be    = core_head_i.be;
        core_mem_req.size  = core_head_i.size;
        core_mem_req.sid   = SID_CORE;
    end

    // ----------------------------------------
    // Round-robin grant
    // ----------------------------------------
    assign has_credit = (mem_crd_q != '0);

    always_comb begin
        walk_grant = 1'b0;
        core_grant = 1'b0;
        if (has_credit) begin
            if (walk_ready_i && core_ready_i) begin
                walk_grant = !prio_core_q;
                core_grant = prio_core_q;
            end else begin
                walk_grant = walk_ready_i;
                core_grant = core_ready_i;
            end
        end
    end

    assign issue           = walk_grant | core_grant;
    assign walk_pop_o      = walk_grant;
    assign core_pop_o      = core_grant;
    assign mem_req_valid_o = issue;
    assign mem_req_o       = core_grant ? core_mem_req : walk_mem_req;

    // Priority and memory credit count
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            prio_core_q <= 1'b0;
            mem_crd_q   <= CRD_W'(`DMEM_MEM_CREDITS);
        end else begin
            if (issue) begin
                prio_core_q <= !prio_core_q;    // Flip on every grant
            end
            case ({issue, mem_credit_i})
                2'b10:   mem_crd_q <= mem_crd_q - CRD_W'(1);
                2'b01:   mem_crd_q <= mem_crd_q + CRD_W'(1);
                default: mem_crd_q <= mem_crd_q;
            endcase
        end
    end

    // ----------------------------------------
    // Response demux, one register stage
    // ----------------------------------------
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            walk_rsp_valid_q <= 1'b0;
            core_rsp_valid_q <= 1'b0;
        end else begin
            walk_rsp_valid_q <= mem_rsp_valid_i && (mem_rsp_i.sid == SID_WALKER);
            core_rsp_valid_q <= mem_rsp_valid_i && (mem_rsp_i.sid == SID_CORE);
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_rsp_valid_i) begin
            rsp_data_q <= mem_rsp_i.rdata;
        end
    end

    assign walk_rsp_valid_o = walk_rsp_valid_q;
    assign core_rsp_valid_o = core_rsp_valid_q;
    assign walk_rsp_data_o  = rsp_data_q;     // Shared, qualified by each valid
    assign core_rsp_data_o  = rsp_data_q;

endmodule

// ==== rtl/hpm_counters.sv ====
/*
 * Event counters of the memory port behind a small register port.
 * Read is combinational; a write beats an increment in the same cycle.
 */

module hpm_counters
    import drac_mem_pkg::*;
(
    input  logic     CLK,
    input  logic     RST,

    // Events, one cycle pulses
    input  logic     walk_grant_i,
    input  logic     core_grant_i,
    input  logic     rsp_i,

    // Register port
    input  hpm_sel_e hpm_sel_i,
    input  logic     hpm_we_i,
    input  hpm_cnt_t hpm_wdata_i,
    output hpm_cnt_t hpm_data_o
);

    localparam int NUM_CNT = 3;

    hpm_cnt_t         cnt_q [NUM_CNT];
    logic [NUM_CNT-1:0] event_vec;

    // Index order follows hpm_sel_e
    assign event_vec[HPM_WALK_GRANTS] = walk_grant_i;
    assign event_vec[HPM_CORE_GRANTS] = core_grant_i;
    assign event_vec[HPM_RESPONSES]   = rsp_i;

    // ----------------------------------------
    // Counter update
    // ----------------------------------------
    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (hpm_we_i && (int'(hpm_sel_i) == i)) begin
                    cnt_q[i] <= hpm_wdata_i;            // Software load wins
                end else if (event_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + hpm_cnt_t'(1);   // Wraps
                end
            end
        end
    end

    // Unmapped select reads zero
    always_comb begin
        hpm_data_o = '0;
        if (int'(hpm_sel_i) < NUM_CNT) begin
            hpm_data_o = cnt_q[hpm_sel_i];
        end
    end

endmodule

// ==== rtl/drac_dmem_top.sv ====
/*
 * Data-memory side of the tile: walker and core share one memory port.
 * Two credit buffers feed the mux; counters watch grants and responses.
 */

`include "drac_mem_defines.svh"

module drac_dmem_top
    import drac_mem_pkg::*;
(
    input  logic                        CLK,
    input  logic                        RST,

    // Page-table walker requests
    input  logic                        walk_valid_i,
    input  walk_req_t                   walk_req_i,
    output logic                        walk_credit_o,

    // Core load/store requests
    input  logic                        core_valid_i,
    input  core_req_t                   core_req_i,
    output logic                        core_credit_o,

    // Memory request and response
    output logic                        mem_req_valid_o,
    output mem_req_t                    mem_req_o,
    input  logic                        mem_credit_i,
    input  logic                        mem_rsp_valid_i,
    input  mem_rsp_t                    mem_rsp_i,

    // Requester responses
    output logic                        walk_rsp_valid_o,
    output logic [`DMEM_DATA_WIDTH-1:0] walk_rsp_data_o,
    output logic                        core_rsp_valid_o,
    output logic [`DMEM_DATA_WIDTH-1:0] core_rsp_data_o,

    // Counter register port
    input  hpm_sel_e                    hpm_sel_i,
    input  logic                        hpm_we_i,
    input  hpm_cnt_t                    hpm_wdata_i,
    output hpm_cnt_t                    hpm_data_o
);

    walk_req_t walk_head;
    core_req_t core_head;
    logic      walk_not_empty;
    logic      core_not_empty;
    logic      walk_pop;    // Also the walker grant event
    logic      core_pop;    // Also the core grant event

    // ----------------------------------------
    // Request buffers
    // ----------------------------------------
    credit_fifo #(.T_PAYLOAD(walk_req_t)) u_walk_fifo (
        .CLK         (CLK),
        .RST         (RST),
        .push_i      (walk_valid_i),
        .push_data_i (walk_req_i),
        .pop_i       (walk_pop),
        .head_o      (walk_head),
        .not_empty_o (walk_not_empty),
        .credit_o    (walk_credit_o)
    );

    credit_fifo #(.T_PAYLOAD(core_req_t)) u_core_fifo (
        .CLK         (CLK),
        .RST         (RST),
        .push_i      (core_valid_i),
        .push_data_i (core_req_i),
        .pop_i       (core_pop),
        .head_o      (core_head),
        .not_empty_o (core_not_empty),
        .credit_o    (core_credit_o)
    );

    // ----------------------------------------
    // Arbitration and routing
    // ----------------------------------------
    dmem_mux u_mux (
        .CLK              (CLK),
        .RST              (RST),
        .walk_head_i      (walk_head),
        .walk_ready_i     (walk_not_empty),
        .core_head_i      (core_head),
        .core_ready_i     (core_not_empty),
        .walk_pop_o       (walk_pop),
        .core_pop_o       (core_pop),
        .mem_credit_i     (mem_credit_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .walk_rsp_valid_o (walk_rsp_valid_o),
        .walk_rsp_data_o  (walk_rsp_data_o),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_data_o  (core_rsp_data_o)
    );

    // Response counted on arrival from memory
    hpm_counters u_hpm (
        .CLK          (CLK),
        .RST          (RST),
        .walk_grant_i (walk_pop),
        .core_grant_i (core_pop),
        .rsp_i        (mem_rsp_valid_i),
        .hpm_sel_i    (hpm_sel_i),
        .hpm_we_i     (hpm_we_i),
        .hpm_wdata_i  (hpm_wdata_i),
        .hpm_data_o   (hpm_data_o)
    );

endmodule

// ==== verification/dmem_props.sv ====
/*
 * Concurrent checks on credit use and response routing of the memory port.
 * Bound into the top level; a violation raises an assertion error.
 */

`include "drac_mem_defines.svh"

module dmem_props (
    input logic CLK,
    input logic RST,
    input logic walk_push_i,
    input logic walk_pop_i,
    input logic core_push_i,
    input logic core_pop_i,
    input logic mem_issue_i,
    input logic mem_credit_i,
    input logic walk_rsp_valid_i,
    input logic core_rsp_valid_i
);

    int walk_occ_q;     // Real buffer occupancy from push and pop
    int core_occ_q;
    int mem_out_q;      // Issued minus credits returned

    always_ff @(posedge CLK, negedge RST) begin
        if (!RST) begin
            walk_occ_q <= 0;
            core_occ_q <= 0;
            mem_out_q  <= 0;
        end else begin
            walk_occ_q <= walk_occ_q + int'(walk_push_i) - int'(walk_pop_i);
            core_occ_q <= core_occ_q + int'(core_push_i) - int'(core_pop_i);
            mem_out_q  <= mem_out_q + int'(mem_issue_i) - int'(mem_credit_i);
        end
    end

    walk_no_overflow: assert property (@(posedge CLK) disable iff (!RST)
        walk_push_i |-> walk_occ_q < `DMEM_FIFO_DEPTH)
        else $error("walker push into a full buffer");

    core_no_overflow: assert property (@(posedge CLK) disable iff (!RST)
        core_push_i |-> core_occ_q < `DMEM_FIFO_DEPTH)
        else $error("core push into a full buffer");

    mem_credit_bound: assert property (@(posedge CLK) disable iff (!RST)
        mem_out_q <= `DMEM_MEM_CREDITS)
        else $error("outstanding memory requests above credit limit");

    // Only one requester gets a response per cycle
    rsp_onehot: assert property (@(posedge CLK) disable iff (!RST)
        !(walk_rsp_valid_i && core_rsp_valid_i))
        else $error("walker and core responses valid together");

endmodule

bind drac_dmem_top dmem_props u_props (
    .CLK              (CLK),
    .RST              (RST),
    .walk_push_i      (walk_valid_i),
    .walk_pop_i       (walk_pop),
    .core_push_i      (core_valid_i),
    .core_pop_i       (core_pop),
    .mem_issue_i      (mem_req_valid_o),
    .mem_credit_i     (mem_credit_i),
    .walk_rsp_valid_i (walk_rsp_valid_o),
    .core_rsp_valid_i (core_rsp_valid_o)
);

// ==== verification/dmem_tb.sv ====
/*
 * Testbench for the shared data-memory port: two random credit requesters,
 * a memory model with random credit and response delays, and a scoreboard.
 */

`include "drac_mem_defines.svh"

module dmem_tb
    import drac_mem_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int NUM_REQ       = 200;                         // Per requester
    localparam int WATCHDOG_TIME = 2 * NUM_REQ * 20 * CLK_PERIOD;

    logic                        CLK;
    logic                        RST;
    logic                        walk_valid;
    walk_req_t                   walk_req;
    logic                        walk_credit;
    logic                        core_valid;
    core_req_t                   core_req;
    logic                        core_credit;
    logic                        mem_req_valid;
    mem_req_t                    mem_req;
    logic                        mem_credit;
    logic                        mem_rsp_valid;
    mem_rsp_t                    mem_rsp;
    logic                        walk_rsp_valid;
    logic [`DMEM_DATA_WIDTH-1:0] walk_rsp_data;
    logic                        core_rsp_valid;
    logic [`DMEM_DATA_WIDTH-1:0] core_rsp_data;
    hpm_sel_e                    hpm_sel;
    logic                        hpm_we;
    hpm_cnt_t                    hpm_wdata;
    hpm_cnt_t                    hpm_data;

    // Scoreboard and memory model state
    mem_req_t walk_exp [$];                 // Expected issues, walker order
    mem_req_t core_exp [$];                 // Expected issues, core order
    int       crd_due [$];                  // Cycle each memory credit returns
    int       rsp_due [$];                  // Pending responses, any order
    sid_e     rsp_sid [$];
    logic [`DMEM_DATA_WIDTH-1:0] rsp_data [$];
    int       walk_crd = `DMEM_FIFO_DEPTH;  // Requester credits
    int       core_crd = `DMEM_FIFO_DEPTH;
    int       mem_crd  = `DMEM_MEM_CREDITS; // DUT's credits toward memory
    int       walk_sent = 0;
    int       core_sent = 0;
    int       cyc = 0;
    hpm_cnt_t n_walk = '0;
    hpm_cnt_t n_core = '0;
    hpm_cnt_t n_rsp  = '0;

    // Response driven last cycle, due on the outputs now
    logic                        prev_valid = 1'b0;
    sid_e                        prev_sid   = SID_WALKER;
    logic [`DMEM_DATA_WIDTH-1:0] prev_data  = '0;

    drac_dmem_top u_drac_dmem_top (
        .CLK              (CLK),
        .RST              (RST),
        .walk_valid_i     (walk_valid),
        .walk_req_i       (walk_req),
        .walk_credit_o    (walk_credit),
        .core_valid_i     (core_valid),
        .core_req_i       (core_req),
        .core_credit_o    (core_credit),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_credit_i     (mem_credit),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_i        (mem_rsp),
        .walk_rsp_valid_o (walk_rsp_valid),
        .walk_rsp_data_o  (walk_rsp_data),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_data_o  (core_rsp_data),
        .hpm_sel_i        (hpm_sel),
        .hpm_we_i         (hpm_we),
        .hpm_wdata_i      (hpm_wdata),
        .hpm_data_o       (hpm_data)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ----------------------------------------
    // Reporting and compare tasks
    // ----------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_mem_req(input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED mem_req_o exp %h got %h", exp, act));
        end
    endtask

    task automatic check_rsp(input sid_e sid, input logic exp_valid, input logic act_valid,
                             input logic [`DMEM_DATA_WIDTH-1:0] exp_data,
                             input logic [`DMEM_DATA_WIDTH-1:0] act_data);
        string name;
        name = (sid == SID_WALKER) ? "walk_rsp" : "core_rsp";
        if (act_valid !== exp_valid) begin
            report_failure($sformatf("FAILED %s_valid_o exp %h got %h",
                                     name, exp_valid, act_valid));
        end else if (exp_valid && (act_data !== exp_data)) begin
            report_failure($sformatf("FAILED %s_data_o exp %h got %h",
                                     name, exp_data, act_data));
        end
    endtask

    task automatic check_hpm(input hpm_sel_e sel, input hpm_cnt_t exp, input hpm_cnt_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED hpm_data_o[%s] exp %h got %h",
                                     sel.name(), exp, act));
        end
    endtask

    task automatic expect_low(input string name, input logic act);
        if (act !== 1'b0) begin
            report_failure($sformatf("FAILED %s exp %h got %h", name, 1'b0, act));
        end
    endtask

    // Counter port access, one cycle per read
    task automatic read_counter(input hpm_sel_e sel, input hpm_cnt_t exp);
        @(posedge CLK);
        #1 hpm_sel = sel;
        @(negedge CLK);
        check_hpm(sel, exp, hpm_data);
    endtask

    task automatic write_counter(input hpm_sel_e sel, input hpm_cnt_t val);
        @(posedge CLK);
        #1;
        hpm_sel   = sel;
        hpm_we    = 1'b1;
        hpm_wdata = val;
        @(posedge CLK);
        #1 hpm_we = 1'b0;
    endtask

    function automatic logic [`DMEM_DATA_WIDTH-1:0] rdata_for(
        input logic [`DMEM_ADDR_WIDTH-1:0] addr);
        return {~addr[23:0], addr};     // Memory contents follow the address
    endfunction

    // ----------------------------------------
    // Stimulus, memory model and scoreboard
    // ----------------------------------------
    initial begin : stimulus
        walk_req_t   w;
        core_req_t   c;
        mem_req_t    exp;
        logic [63:0] r64;
        int          idx;
        bit          done;
        hpm_cnt_t    wval;
        void'($urandom(51176));
        RST           = 1'b0;
        walk_valid    = 1'b0;
        walk_req      = '0;
        core_valid    = 1'b0;
        core_req      = '0;
        mem_credit    = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        hpm_sel       = HPM_WALK_GRANTS;
        hpm_we        = 1'b0;
        hpm_wdata     = '0;
        done          = 1'b0;
        repeat (10) @(posedge CLK);
        #1 RST = 1'b1;

        // Quiet outputs and cleared counters out of reset
        @(negedge CLK);
        expect_low("mem_req_valid_o", mem_req_valid);
        expect_low("walk_credit_o", walk_credit);
        expect_low("core_credit_o", core_credit);
        expect_low("walk_rsp_valid_o", walk_rsp_valid);
        expect_low("core_rsp_valid_o", core_rsp_valid);
        read_counter(HPM_WALK_GRANTS, '0);
        read_counter(HPM_CORE_GRANTS, '0);
        read_counter(HPM_RESPONSES, '0);

        while (!done) begin
            @(posedge CLK);
            #1;
            cyc++;
            walk_valid = 1'b0;              // Walker spends a credit per request
            if (walk_sent < NUM_REQ && walk_crd > 0 && $urandom % 3 != 0) begin
                r64     = {$urandom, $urandom};
                w.addr  = r64[`DMEM_ADDR_WIDTH-1:0];
                w.cmd   = ($urandom % 4 == 0) ? `DMEM_WALK_CMD_AMO_OR : walk_cmd_t'($urandom);
                w.wdata = {$urandom, $urandom};
                w.size  = mem_size_t'($urandom);
                exp.addr  = w.addr;
                exp.wdata = w.wdata;
                exp.size  = w.size;
                exp.op    = (w.cmd == `DMEM_WALK_CMD_AMO_OR) ? AMO_OR : LOAD;
                exp.be    = (exp.op == AMO_OR) ? '1 : '0;
                exp.sid   = SID_WALKER;
                walk_exp.push_back(exp);
                walk_req   = w;
                walk_valid = 1'b1;
                walk_crd--;
                walk_sent++;
            end
            core_valid = 1'b0;              // Core fields pass through unchanged
            if (core_sent < NUM_REQ && core_crd > 0 && $urandom % 3 != 0) begin
                r64     = {$urandom, $urandom};
                c.addr  = r64[`DMEM_ADDR_WIDTH-1:0];
                c.wdata = {$urandom, $urandom};
                c.op    = mem_op_e'(2'($urandom % 3));
                c.be    = 8'($urandom);
                c.size  = mem_size_t'($urandom);
                exp.addr  = c.addr;
                exp.wdata = c.wdata;
                exp.op    = c.op;
                exp.be    = c.be;
                exp.size  = c.size;
                exp.sid   = SID_CORE;
                core_exp.push_back(exp);
                core_req   = c;
                core_valid = 1'b1;
                core_crd--;
                core_sent++;
            end

            // Memory returns at most one credit per cycle
            mem_credit = 1'b0;
            idx = -1;
            foreach (crd_due[i]) begin
                if (idx < 0 && crd_due[i] <= cyc) begin
                    idx = i;
                end
            end
            if (idx >= 0) begin
                crd_due.delete(idx);
                mem_credit = 1'b1;
            end

            // Any due response may go first
            mem_rsp_valid = 1'b0;
            idx = -1;
            foreach (rsp_due[i]) begin
                if (idx < 0 && rsp_due[i] <= cyc) begin
                    idx = i;
                end
            end
            if (idx >= 0) begin
                mem_rsp.sid   = rsp_sid[idx];
                mem_rsp.rdata = rsp_data[idx];
                rsp_due.delete(idx);
                rsp_sid.delete(idx);
                rsp_data.delete(idx);
                mem_rsp_valid = 1'b1;
                n_rsp = n_rsp + 1;
            end

            @(negedge CLK);
            check_rsp(SID_WALKER, prev_valid && prev_sid == SID_WALKER, walk_rsp_valid,
                      prev_data, walk_rsp_data);
            check_rsp(SID_CORE, prev_valid && prev_sid == SID_CORE, core_rsp_valid,
                      prev_data, core_rsp_data);
            prev_valid = mem_rsp_valid;
            prev_sid   = mem_rsp.sid;
            prev_data  = mem_rsp.rdata;

            if (walk_credit && core_credit) begin
                report_failure("Both requesters got a credit in the same cycle");
            end
            if (mem_req_valid !== (walk_credit || core_credit)) begin
                report_failure("Memory issue and requester credit pulse are not aligned");
            end
            if (mem_req_valid) begin
                if (mem_crd == 0) begin
                    report_failure("Request issued while the DUT had no memory credit");
                end
                if (walk_credit) begin
                    if (walk_exp.size() == 0) begin
                        report_failure("Walker request issued that was never sent");
                    end
                    check_mem_req(walk_exp.pop_front(), mem_req);
                    walk_crd++;
                    n_walk = n_walk + 1;
                end else begin
                    if (core_exp.size() == 0) begin
                        report_failure("Core request issued that was never sent");
                    end
                    check_mem_req(core_exp.pop_front(), mem_req);
                    core_crd++;
                    n_core = n_core + 1;
                end
                mem_crd--;
                crd_due.push_back(cyc + 1 + int'($urandom % 6));
                rsp_due.push_back(cyc + 1 + int'($urandom % 8));
                rsp_sid.push_back(mem_req.sid);     // Memory echoes the tag
                rsp_data.push_back(rdata_for(mem_req.addr));
            end
            if (mem_credit) begin
                mem_crd++;
            end

            // Last credit pulse must drop before leaving the loop
            done = (walk_sent == NUM_REQ) && (core_sent == NUM_REQ) &&
                   (walk_exp.size() == 0) && (core_exp.size() == 0) &&
                   (crd_due.size() == 0) && (rsp_due.size() == 0) && !prev_valid &&
                   !mem_credit;
        end

        // Totals after quiescence, then software load and readback
        read_counter(HPM_WALK_GRANTS, n_walk);
        read_counter(HPM_CORE_GRANTS, n_core);
        read_counter(HPM_RESPONSES, n_rsp);
        for (int s = 0; s < 3; s++) begin
            wval = hpm_cnt_t'($urandom);
            write_counter(hpm_sel_e'(2'(s)), wval);
            read_counter(hpm_sel_e'(2'(s)), wval);
        end

        $display("TEST OK");
        $finish;
    end

    // Hang guard sized from the request count
    initial begin : watchdog
        #(WATCHDOG_TIME);
        report_failure("Watchdog expired before all requests and responses completed");
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/drac_mem_pkg.sv
rtl/credit_fifo.sv
rtl/dmem_mux.sv
rtl/hpm_counters.sv
rtl/drac_dmem_top.sv
verification/dmem_props.sv
verification/dmem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the data-memory port testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f --top-module dmem_tb -Mdir obj_dir -o dmem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/dmem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
